// ==== list.f ====
+incdir+rtl
rtl/mips_pkg.sv
rtl/instr_fetch.sv
rtl/fetch_buffer.sv
rtl/control_unit.sv
rtl/register_file.sv
rtl/instruction_decode.sv
rtl/decode_subsystem.sv
verification/tb_decode_subsystem.sv

// ==== rtl/control_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module control_unit (
    input  wire  mips_pkg::opcode_e  i_opcode,
    input  wire  mips_pkg::funct_e   i_funct,
    output mips_pkg::ctrl_t          o_ctrl
);

    always_comb begin
        o_ctrl = '0;  // unknown codes and halt
        case (i_opcode)
            mips_pkg::OP_RTYPE: begin
                case (i_funct)
                    mips_pkg::FN_ADD, mips_pkg::FN_SUB, mips_pkg::FN_AND, mips_pkg::FN_OR: begin
                        o_ctrl.reg_dst   = 1'b1;
                        o_ctrl.reg_write = 1'b1;
                        o_ctrl.alu_op    = mips_pkg::ALU_RTYPE;
                    end
                    mips_pkg::FN_SLL: begin
                        o_ctrl.reg_dst   = 1'b1;
                        o_ctrl.reg_write = 1'b1;
                        o_ctrl.alu_src   = 2'b10;  // shift by shamt
                        o_ctrl.alu_op    = mips_pkg::ALU_RTYPE;
                    end
                    mips_pkg::FN_JR: begin
                        o_ctrl.jump = 1'b1;
                    end
                    mips_pkg::FN_JALR: begin
                        o_ctrl.jump      = 1'b1;
                        o_ctrl.reg_dst   = 1'b1;
                        o_ctrl.reg_write = 1'b1;  // link into rd
                        o_ctrl.alu_op    = mips_pkg::ALU_ADD;
                    end
                    default: o_ctrl = '0;
                endcase
            end
            mips_pkg::OP_ADDI: begin
                o_ctrl.imm_flag  = 1'b1;
                o_ctrl.sign_flag = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_src   = 2'b01;
                o_ctrl.alu_op    = mips_pkg::ALU_ADD;
            end
            mips_pkg::OP_ANDI, mips_pkg::OP_ORI: begin
                o_ctrl.imm_flag  = 1'b1;  // zero-extended
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_src   = 2'b01;
                o_ctrl.alu_op    = mips_pkg::ALU_LOGIC;
            end
            mips_pkg::OP_LW: begin
                o_ctrl.imm_flag  = 1'b1;
                o_ctrl.sign_flag = 1'b1;
                o_ctrl.mem_read  = 1'b1;
                o_ctrl.mem2reg   = 1'b1;
                o_ctrl.reg_write = 1'b1;
                o_ctrl.alu_src   = 2'b01;
                o_ctrl.width     = 2'b11;
                o_ctrl.alu_op    = mips_pkg::ALU_ADD;
            end
            mips_pkg::OP_SW: begin
                o_ctrl.imm_flag  = 1'b1;
                o_ctrl.sign_flag = 1'b1;
                o_ctrl.mem_write = 1'b1;
                o_ctrl.alu_src   = 2'b01;
                o_ctrl.width     = 2'b11;
                o_ctrl.alu_op    = mips_pkg::ALU_ADD;
            end
            mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
                o_ctrl.branch    = 1'b1;
                o_ctrl.sign_flag = 1'b1;  // signed word offset
                o_ctrl.alu_op    = mips_pkg::ALU_SUB;
            end
            mips_pkg::OP_J: begin
                o_ctrl.jump = 1'b1;
            end
            mips_pkg::OP_JAL: begin
                o_ctrl.jump      = 1'b1;
                o_ctrl.reg_write = 1'b1;  // link into r31
                o_ctrl.alu_op    = mips_pkg::ALU_ADD;
            end
            default: o_ctrl = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/decode_subsystem.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "mips_params.svh"

module decode_subsystem (
    input  wire                         clk,
    input  wire                         i_rst_n,
    input  wire                         i_start,
    input  wire                         i_load_we,
    input  wire  [`MIPS_IMEM_AW-1:0]    i_load_addr,
    input  wire  [`MIPS_NB_DATA-1:0]    i_load_data,
    input  wire  mips_pkg::wb_t         i_wb,
    output logic                        o_dec_valid,
    output mips_pkg::decode_t           o_dec,
    input  wire                         i_dec_ready,
    output logic                        o_stop
);

    logic                           fetch_valid;
    logic                           fetch_ready;
    mips_pkg::fetch_t               fetch_data;
    logic                           buf_valid;
    logic                           buf_ready;
    mips_pkg::fetch_t               buf_data;
    mips_pkg::redirect_t            redirect;
    logic [`MIPS_NB_REG_ADDR-1:0]   rd_addr1;
    logic [`MIPS_NB_REG_ADDR-1:0]   rd_addr2;
    logic [`MIPS_NB_DATA-1:0]       rd_data1;
    logic [`MIPS_NB_DATA-1:0]       rd_data2;
    mips_pkg::opcode_e              opcode;
    mips_pkg::funct_e               funct;
    mips_pkg::ctrl_t                ctrl;

    instr_fetch fetch0 (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_load_we   (i_load_we),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .i_redirect  (redirect),
        .o_valid     (fetch_valid),
        .o_fetch     (fetch_data),
        .i_ready     (fetch_ready)
    );

    fetch_buffer fbuf0 (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_flush (redirect.valid),  // taken jump drops wrong-path words
        .i_valid (fetch_valid),
        .i_data  (fetch_data),
        .o_ready (fetch_ready),
        .o_valid (buf_valid),
        .o_data  (buf_data),
        .i_ready (buf_ready)
    );

    instruction_decode dec0 (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_valid     (buf_valid),
        .i_fetch     (buf_data),
        .o_ready     (buf_ready),
        .o_rd_addr1  (rd_addr1),
        .o_rd_addr2  (rd_addr2),
        .i_rd_data1  (rd_data1),
        .i_rd_data2  (rd_data2),
        .o_opcode    (opcode),
        .o_funct     (funct),
        .i_ctrl      (ctrl),
        .o_redirect  (redirect),
        .o_dec_valid (o_dec_valid),
        .o_dec       (o_dec),
        .i_dec_ready (i_dec_ready),
        .o_stop      (o_stop)
    );

    register_file rf0 (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_wb       (i_wb),
        .i_rd_addr1 (rd_addr1),
        .i_rd_addr2 (rd_addr2),
        .o_rd_data1 (rd_data1),
        .o_rd_data2 (rd_data2)
    );

    control_unit ctrl0 (
        .i_opcode (opcode),
        .i_funct  (funct),
        .o_ctrl   (ctrl)
    );

endmodule

`default_nettype wire

// ==== rtl/fetch_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "mips_params.svh"

module fetch_buffer (
    input  wire                     clk,
    input  wire                     i_rst_n,
    input  wire                     i_flush,
    input  wire                     i_valid,
    input  wire  mips_pkg::fetch_t  i_data,
    output logic                    o_ready,
    output logic                    o_valid,
    output mips_pkg::fetch_t        o_data,
    input  wire                     i_ready
);

    mips_pkg::fetch_t                   mem [`MIPS_FB_DEPTH];
    logic [$clog2(`MIPS_FB_DEPTH)-1:0]  wr_ptr;
    logic [$clog2(`MIPS_FB_DEPTH)-1:0]  rd_ptr;
    logic [$clog2(`MIPS_FB_DEPTH):0]    count;
    logic                               push;
    logic                               pop;

    assign o_ready = (count != `MIPS_FB_DEPTH);
    assign o_valid = (count != 0);
    assign o_data  = mem[rd_ptr];
    assign push    = i_valid && o_ready;
    assign pop     = o_valid && i_ready;

    always_ff @(posedge clk) begin
        if (push && !i_flush) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (i_flush) begin
            // wrong-path words, a push in this cycle included
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // full buffer takes no push, empty buffer gives no pop
    assert property (@(posedge clk) disable iff (!i_rst_n)
        (count == `MIPS_FB_DEPTH && !pop && !i_flush) |=> (count == `MIPS_FB_DEPTH && $stable(o_data)))
        else $error("push into full buffer");

    assert property (@(posedge clk) disable iff (!i_rst_n)
        (count == 0 && !push) |=> (count == 0))
        else $error("pop from empty buffer");

endmodule

`default_nettype wire

// ==== rtl/instr_fetch.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "mips_params.svh"

module instr_fetch (
    input  wire                        clk,
    input  wire                        i_rst_n,
    input  wire                        i_start,
    input  wire                        i_load_we,
    input  wire  [`MIPS_IMEM_AW-1:0]   i_load_addr,
    input  wire  [`MIPS_NB_DATA-1:0]   i_load_data,
    input  wire  mips_pkg::redirect_t  i_redirect,
    output logic                       o_valid,
    output mips_pkg::fetch_t           o_fetch,
    input  wire                        i_ready
);

    logic [`MIPS_NB_DATA-1:0] imem [`MIPS_IMEM_DEPTH];
    logic [`MIPS_NB_DATA-1:0] pc;
    logic                     run;

    // program load, only while the pipeline is held
    always_ff @(posedge clk) begin
        if (i_load_we && !i_start) begin
            imem[i_load_addr] <= i_load_data;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            run <= 1'b0;
            pc  <= '0;
        end else begin
            if (i_start) begin
                run <= 1'b1;  // stays set until reset
            end
            if (i_redirect.valid) begin
                pc <= i_redirect.target;
            end else if (o_valid && i_ready) begin
                pc <= pc + 4;
            end
        end
    end

    assign o_valid       = run;
    assign o_fetch.instr = imem[pc[`MIPS_IMEM_AW+1:2]];  // word index, byte offset dropped
    assign o_fetch.pc4   = pc + 4;

    // a stalled word may only change through a redirect
    assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_valid && !i_ready && !i_redirect.valid) |=> (o_valid && $stable(o_fetch)))
        else $error("fetch payload changed while stalled");

endmodule

`default_nettype wire

// ==== rtl/instruction_decode.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "mips_params.svh"

module instruction_decode (
    input  wire                           clk,
    input  wire                           i_rst_n,
    input  wire                           i_valid,
    input  wire  mips_pkg::fetch_t        i_fetch,
    output logic                          o_ready,
    output logic [`MIPS_NB_REG_ADDR-1:0]  o_rd_addr1,
    output logic [`MIPS_NB_REG_ADDR-1:0]  o_rd_addr2,
    input  wire  [`MIPS_NB_DATA-1:0]      i_rd_data1,
    input  wire  [`MIPS_NB_DATA-1:0]      i_rd_data2,
    output mips_pkg::opcode_e             o_opcode,
    output mips_pkg::funct_e              o_funct,
    input  wire  mips_pkg::ctrl_t         i_ctrl,
    output mips_pkg::redirect_t           o_redirect,
    output logic                          o_dec_valid,
    output mips_pkg::decode_t             o_dec,
    input  wire                           i_dec_ready,
    output logic                          o_stop
);

    logic [`MIPS_NB_DATA-1:0] instr;
    logic [`MIPS_NB_DATA-1:0] pc4;
    logic [`MIPS_NB_DATA-1:0] imm_ext;
    logic [`MIPS_NB_DATA-1:0] target;
    logic                     taken;
    logic [1:0]               jump_case;
    logic                     is_halt;
    logic                     is_link;
    logic                     accept;
    mips_pkg::decode_t        d_next;

    assign instr      = i_fetch.instr;
    assign pc4        = i_fetch.pc4;
    assign o_opcode   = mips_pkg::opcode_e'(instr[31:26]);
    assign o_funct    = mips_pkg::funct_e'(instr[5:0]);
    assign o_rd_addr1 = instr[25:21];
    assign o_rd_addr2 = instr[20:16];
    assign is_halt    = (instr == `MIPS_HALT_WORD);
    assign is_link    = (o_opcode == mips_pkg::OP_JAL) ||
                        (o_opcode == mips_pkg::OP_RTYPE && o_funct == mips_pkg::FN_JALR);

    assign imm_ext = i_ctrl.sign_flag ? {{(`MIPS_NB_DATA-16){instr[15]}}, instr[15:0]}
                                      : {{(`MIPS_NB_DATA-16){1'b0}}, instr[15:0]};

    // output slot free or draining, and no halt seen yet
    assign o_ready = !o_stop && (!o_dec_valid || i_dec_ready);
    assign accept  = i_valid && o_ready;

    // branch and jump resolution
    always_comb begin
        taken     = 1'b0;
        target    = pc4 + (imm_ext << 2);
        jump_case = 2'd0;
        if (i_ctrl.jump || i_ctrl.branch) begin
            case (o_opcode)
                mips_pkg::OP_RTYPE: begin  // jr, jalr
                    taken  = 1'b1;
                    target = i_rd_data1;
                    if (o_funct == mips_pkg::FN_JALR) jump_case = 2'd2;
                end
                mips_pkg::OP_BEQ: begin
                    taken = (i_rd_data1 == i_rd_data2);
                    if (taken) jump_case = 2'd1;
                end
                mips_pkg::OP_BNE: begin
                    taken = (i_rd_data1 != i_rd_data2);
                    if (taken) jump_case = 2'd1;
                end
                mips_pkg::OP_J, mips_pkg::OP_JAL: begin
                    taken  = 1'b1;
                    target = {pc4[`MIPS_NB_DATA-1:`MIPS_NB_DATA-4], instr[25:0], 2'b00};
                    if (o_opcode == mips_pkg::OP_JAL) jump_case = 2'd2;
                end
                default: taken = 1'b0;
            endcase
        end
    end

    assign o_redirect.valid  = accept && taken;
    assign o_redirect.target = target;

    always_comb begin
        d_next.rs        = o_rd_addr1;
        d_next.rt        = o_rd_addr2;
        d_next.rd        = instr[15:11];
        d_next.shamt     = instr[10:6];
        d_next.opcode    = o_opcode;
        d_next.funct     = o_funct;
        d_next.reg_da    = i_rd_data1;
        d_next.reg_db    = i_rd_data2;
        d_next.immediate = imm_ext;
        d_next.jump_case = jump_case;
        d_next.stop      = is_halt;
        d_next.ctrl      = i_ctrl;
        if (is_link) begin
            // link value is built downstream as pc4 + 4
            d_next.reg_da = pc4;
            d_next.reg_db = 4;
            d_next.rs     = '0;
            if (o_opcode == mips_pkg::OP_JAL) d_next.rt = '1;  // r31
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dec_valid <= 1'b0;
            o_stop      <= 1'b0;
        end else begin
            if (accept) begin
                o_dec_valid <= 1'b1;
            end else if (i_dec_ready) begin
                o_dec_valid <= 1'b0;
            end
            if (accept && is_halt) o_stop <= 1'b1;  // sticky until reset
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_dec <= d_next;
        end
    end

    // held record stays put until the consumer takes it
    assert property (@(posedge clk) disable iff (!i_rst_n)
        (o_dec_valid && !i_dec_ready) |=> (o_dec_valid && $stable(o_dec)))
        else $error("decode record changed under back-pressure");

endmodule

`default_nettype wire

// ==== rtl/mips_params.svh ====
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// datapath and register file
`define MIPS_NB_DATA      32
`define MIPS_NB_REG_ADDR  5

// instruction memory, in words
`define MIPS_IMEM_DEPTH   64
`define MIPS_IMEM_AW      6

// fetch to decode buffer
`define MIPS_FB_DEPTH     2

// last word of a program
`define MIPS_HALT_WORD    32'hFFFF_FFFF

`endif

// ==== rtl/mips_pkg.sv ====
`default_nettype none
`include "mips_params.svh"

package mips_pkg;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_J     = 6'b000010,
        OP_JAL   = 6'b000011,
        OP_BEQ   = 6'b000100,
        OP_BNE   = 6'b000101,
        OP_ADDI  = 6'b001000,
        OP_ANDI  = 6'b001100,
        OP_ORI   = 6'b001101,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011,
        OP_HALT  = 6'b111111  // top code, only seen in the halt word
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_JR   = 6'b001000,
        FN_JALR = 6'b001001,
        FN_ADD  = 6'b100000,
        FN_SUB  = 6'b100010,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101
    } funct_e;

    typedef enum logic [1:0] {
        ALU_ADD   = 2'b00,
        ALU_SUB   = 2'b01,
        ALU_RTYPE = 2'b10,  // operation taken from funct
        ALU_LOGIC = 2'b11
    } alu_op_e;

    typedef struct packed {
        logic [`MIPS_NB_DATA-1:0] instr;
        logic [`MIPS_NB_DATA-1:0] pc4;
    } fetch_t;

    typedef struct packed {
        logic       jump;
        logic       branch;
        logic       reg_dst;
        logic       mem2reg;
        logic       mem_read;
        logic       mem_write;
        logic       imm_flag;
        logic       sign_flag;
        logic       reg_write;
        logic [1:0] alu_src;  // 01 immediate, 10 shamt
        logic [1:0] width;    // 11 full word
        alu_op_e    alu_op;
    } ctrl_t;

    typedef struct packed {
        logic [`MIPS_NB_REG_ADDR-1:0] rs;
        logic [`MIPS_NB_REG_ADDR-1:0] rt;
        logic [`MIPS_NB_REG_ADDR-1:0] rd;
        logic [4:0]                   shamt;
        opcode_e                      opcode;
        funct_e                       funct;
        logic [`MIPS_NB_DATA-1:0]     reg_da;
        logic [`MIPS_NB_DATA-1:0]     reg_db;
        logic [`MIPS_NB_DATA-1:0]     immediate;
        logic [1:0]                   jump_case;  // 0 none, 1 branch, 2 link
        logic                         stop;
        ctrl_t                        ctrl;
    } decode_t;

    typedef struct packed {
        logic                         we;
        logic [`MIPS_NB_REG_ADDR-1:0] addr;
        logic [`MIPS_NB_DATA-1:0]     data;
    } wb_t;

    typedef struct packed {
        logic                     valid;
        logic [`MIPS_NB_DATA-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

// ==== rtl/register_file.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "mips_params.svh"

module register_file (
    input  wire                           clk,
    input  wire                           i_rst_n,
    input  wire  mips_pkg::wb_t           i_wb,
    input  wire  [`MIPS_NB_REG_ADDR-1:0]  i_rd_addr1,
    input  wire  [`MIPS_NB_REG_ADDR-1:0]  i_rd_addr2,
    output logic [`MIPS_NB_DATA-1:0]      o_rd_data1,
    output logic [`MIPS_NB_DATA-1:0]      o_rd_data2
);

    logic [`MIPS_NB_DATA-1:0] regs [2**`MIPS_NB_REG_ADDR];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < 2**`MIPS_NB_REG_ADDR; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb.we && (i_wb.addr != '0)) begin
            regs[i_wb.addr] <= i_wb.data;  // r0 never written
        end
    end

    // no write-through, a same-cycle write shows on the next read
    assign o_rd_data1 = regs[i_rd_addr1];
    assign o_rd_data2 = regs[i_rd_addr2];

endmodule

`default_nettype wire

// ==== verification/tb_decode_subsystem.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "mips_params.svh"

module tb_decode_subsystem;

    localparam int MAX_ROWS = 16;

    logic                        clk;
    logic                        i_rst_n;
    logic                        i_start;
    logic                        i_load_we;
    logic [`MIPS_IMEM_AW-1:0]    i_load_addr;
    logic [`MIPS_NB_DATA-1:0]    i_load_data;
    mips_pkg::wb_t               wb_in;
    logic                        o_dec_valid;
    mips_pkg::decode_t           o_dec;
    logic                        i_dec_ready;
    logic                        o_stop;

    // expected records in executed-path order
    logic [31:0]       t_pc   [MAX_ROWS];
    logic [31:0]       t_word [MAX_ROWS];
    logic [4:0]        t_rs   [MAX_ROWS];
    logic [4:0]        t_rt   [MAX_ROWS];
    logic [4:0]        t_rd   [MAX_ROWS];
    logic [31:0]       t_da   [MAX_ROWS];
    logic [31:0]       t_db   [MAX_ROWS];
    logic [31:0]       t_imm  [MAX_ROWS];
    logic [1:0]        t_jc   [MAX_ROWS];
    logic              t_stop [MAX_ROWS];
    mips_pkg::ctrl_t   t_ctrl [MAX_ROWS];

    logic [31:0]       prog [`MIPS_IMEM_DEPTH];  // image written through the load port
    logic [31:0]       rv [1:6];                 // preloaded register values
    int                n_rows;
    int                row;
    int                k;
    int                errors;
    int                errs_before;
    int                rows_passed;
    int                rows_failed;
    int                cycles;
    int                limit;
    integer            seed;
    logic              timed_out;

    decode_subsystem dut0 (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_load_we   (i_load_we),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .i_wb        (wb_in),
        .o_dec_valid (o_dec_valid),
        .o_dec       (o_dec),
        .i_dec_ready (i_dec_ready),
        .o_stop      (o_stop)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic [31:0] enc_r(input logic [4:0] rs, rt, rd, sh, input logic [5:0] fn);
        return {6'b000000, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs, rt,
                                          input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [31:0] target);
        return {op, target[27:2]};  // word index of the byte target
    endfunction

    function automatic logic [31:0] ext16(input logic [31:0] w, input logic sext);
        return sext ? {{16{w[15]}}, w[15:0]} : {16'h0000, w[15:0]};
    endfunction

    // flag bits in order jump branch reg_dst mem2reg mem_read mem_write imm sign reg_write
    function automatic mips_pkg::ctrl_t ctrl_of(input logic [8:0] flags,
                                                input logic [1:0] src, wd, aop);
        return {flags, src, wd, aop};
    endfunction

    task automatic add_row(input logic [31:0] pc, w, da, db, input logic sext,
                           input logic [1:0] jc, input mips_pkg::ctrl_t c);
        t_pc[n_rows]   = pc;
        t_word[n_rows] = w;
        t_rs[n_rows]   = w[25:21];
        t_rt[n_rows]   = w[20:16];
        t_rd[n_rows]   = w[15:11];
        if (jc == 2'd2) begin
            t_rs[n_rows] = 5'd0;  // link record
            if (w[31:26] == mips_pkg::OP_JAL) t_rt[n_rows] = 5'd31;
        end
        t_da[n_rows]   = da;
        t_db[n_rows]   = db;
        t_imm[n_rows]  = ext16(w, sext);
        t_jc[n_rows]   = jc;
        t_stop[n_rows] = (w == `MIPS_HALT_WORD);
        t_ctrl[n_rows] = c;
        prog[pc[`MIPS_IMEM_AW+1:2]] = w;
        n_rows++;
    endtask

    task automatic check_value(input string name, input logic [31:0] got, exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_record(input int r);
        check_value("rs", o_dec.rs, t_rs[r]);
        check_value("rt", o_dec.rt, t_rt[r]);
        check_value("rd", o_dec.rd, t_rd[r]);
        check_value("shamt", o_dec.shamt, t_word[r][10:6]);
        check_value("opcode", o_dec.opcode, t_word[r][31:26]);
        check_value("funct", o_dec.funct, t_word[r][5:0]);
        check_value("reg_da", o_dec.reg_da, t_da[r]);
        check_value("reg_db", o_dec.reg_db, t_db[r]);
        check_value("immediate", o_dec.immediate, t_imm[r]);
        check_value("jump_case", o_dec.jump_case, t_jc[r]);
        check_value("stop", o_dec.stop, t_stop[r]);
        check_value("ctrl", o_dec.ctrl, t_ctrl[r]);
        check_value("o_stop", o_stop, t_stop[r]);  // rises with the halt record
    endtask

    initial begin
        seed        = 88403;
        i_rst_n     = 1'b0;
        i_start     = 1'b0;
        i_load_we   = 1'b0;
        i_load_addr = '0;
        i_load_data = '0;
        wb_in       = '0;
        i_dec_ready = 1'b0;
        n_rows      = 0;
        errors      = 0;
        rows_passed = 0;
        rows_failed = 0;
        cycles      = 0;
        timed_out   = 1'b0;
        rv[1] = 32'h0000_1234;
        rv[2] = 32'hFFFF_8000;
        rv[3] = 32'h0000_00A5;
        rv[4] = 32'h1357_9BDF;
        rv[5] = 32'h0000_0040;  // jalr target at word 16
        rv[6] = 32'h0000_0060;  // jr target at word 24
        for (k = 0; k < `MIPS_IMEM_DEPTH; k++) begin
            prog[k] = enc_i(mips_pkg::OP_ORI, 5'd0, 5'd15, k[15:0]);  // filler holding its address
        end

        add_row(0, enc_r(1, 2, 7, 0, mips_pkg::FN_ADD), rv[1], rv[2], 0, 0,
                ctrl_of(9'b001000001, 2'b00, 2'b00, mips_pkg::ALU_RTYPE));
        add_row(4, enc_i(mips_pkg::OP_ADDI, 3, 8, 16'hFFFB), rv[3], 0, 1, 0,
                ctrl_of(9'b000000111, 2'b01, 2'b00, mips_pkg::ALU_ADD));
        add_row(8, enc_i(mips_pkg::OP_ORI, 4, 9, 16'h8001), rv[4], 0, 0, 0,
                ctrl_of(9'b000000101, 2'b01, 2'b00, mips_pkg::ALU_LOGIC));
        add_row(12, enc_i(mips_pkg::OP_LW, 1, 10, 16'h8004), rv[1], 0, 1, 0,
                ctrl_of(9'b000110111, 2'b01, 2'b11, mips_pkg::ALU_ADD));
        add_row(16, enc_i(mips_pkg::OP_SW, 6, 3, 16'h0010), rv[6], rv[3], 1, 0,
                ctrl_of(9'b000001110, 2'b01, 2'b11, mips_pkg::ALU_ADD));
        add_row(20, enc_r(0, 2, 11, 3, mips_pkg::FN_SLL), 0, rv[2], 0, 0,
                ctrl_of(9'b001000001, 2'b10, 2'b00, mips_pkg::ALU_RTYPE));
        add_row(24, enc_i(mips_pkg::OP_BNE, 2, 2, 16'd5), rv[2], rv[2], 1, 0,  // not taken
                ctrl_of(9'b010000010, 2'b00, 2'b00, mips_pkg::ALU_SUB));
        add_row(28, enc_i(mips_pkg::OP_BEQ, 1, 1, 16'd3), rv[1], rv[1], 1, 1,  // to 44
                ctrl_of(9'b010000010, 2'b00, 2'b00, mips_pkg::ALU_SUB));
        add_row(44, enc_j(mips_pkg::OP_J, 56), 0, 0, 0, 0,
                ctrl_of(9'b100000000, 2'b00, 2'b00, mips_pkg::ALU_ADD));
        add_row(56, enc_j(mips_pkg::OP_JAL, 80), 60, 4, 0, 2,
                ctrl_of(9'b100000001, 2'b00, 2'b00, mips_pkg::ALU_ADD));
        add_row(80, enc_r(5, 0, 31, 0, mips_pkg::FN_JALR), 84, 4, 0, 2,
                ctrl_of(9'b101000001, 2'b00, 2'b00, mips_pkg::ALU_ADD));
        add_row(64, enc_r(5, 6, 13, 0, mips_pkg::FN_AND), rv[5], rv[6], 0, 0,
                ctrl_of(9'b001000001, 2'b00, 2'b00, mips_pkg::ALU_RTYPE));
        add_row(68, enc_r(6, 0, 0, 0, mips_pkg::FN_JR), rv[6], 0, 0, 0,
                ctrl_of(9'b100000000, 2'b00, 2'b00, mips_pkg::ALU_ADD));
        add_row(96, enc_i(mips_pkg::OP_ANDI, 2, 14, 16'hF0F0), rv[2], 0, 0, 0,
                ctrl_of(9'b000000101, 2'b01, 2'b00, mips_pkg::ALU_LOGIC));
        add_row(100, `MIPS_HALT_WORD, 0, 0, 0, 0, '0);
        limit = 10 * n_rows + 50;

        repeat (2) @(posedge clk);
        #2 i_rst_n = 1'b1;

        i_load_we = 1'b1;
        for (k = 0; k < `MIPS_IMEM_DEPTH; k++) begin
            i_load_addr = k[`MIPS_IMEM_AW-1:0];
            i_load_data = prog[k];
            @(posedge clk);
            #2;
        end
        i_load_we = 1'b0;
        wb_in.we  = 1'b1;
        for (k = 1; k <= 6; k++) begin
            wb_in.addr = k[4:0];
            wb_in.data = rv[k];
            @(posedge clk);
            #2;
        end
        wb_in   = '0;
        i_start = 1'b1;

        // one pass per clock with transfers sampled at the falling edge
        row = 0;
        while (row < n_rows && !timed_out) begin
            i_dec_ready = 1'($random(seed) & 1);
            @(negedge clk);
            if (o_dec_valid && i_dec_ready) begin
                errs_before = errors;
                check_record(row);
                if (errors == errs_before) begin
                    rows_passed++;
                    $display("row %0d pc 0x%h word 0x%h ok", row, t_pc[row], t_word[row]);
                end else begin
                    rows_failed++;
                    $display("row %0d pc 0x%h word 0x%h mismatch", row, t_pc[row], t_word[row]);
                end
                row++;
            end
            cycles++;
            if (cycles >= limit) timed_out = 1'b1;
            @(posedge clk);
            #2;
        end

        if (timed_out) begin
            $display("timed out after %0d cycles with %0d of %0d records seen",
                     cycles, row, n_rows);
            errors++;
        end else begin
            errs_before = errors;
            repeat (20) begin
                i_dec_ready = 1'($random(seed) & 1);
                @(negedge clk);
                check_value("o_dec_valid", o_dec_valid, 1'b0);  // nothing after halt
                check_value("o_stop", o_stop, 1'b1);
                @(posedge clk);
                #2;
            end
            if (errors == errs_before) begin
                rows_passed++;
                $display("halt hold for 20 cycles ok");
            end else begin
                rows_failed++;
                $display("halt hold for 20 cycles failed");
            end
        end

        $display("tests passed %0d failed %0d errors %0d", rows_passed, rows_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
